//--- rtl/rv_mem_pkg.sv
package rv_mem_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  byte_mask_t;

    // funct3[1:0] gives the access size, funct3[2] the unsigned load variants
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } mem_funct3_e;

    // stores reuse the size codes of the signed loads
    localparam mem_funct3_e sb = lb;
    localparam mem_funct3_e sh = lh;
    localparam mem_funct3_e sw = lw;

    function automatic byte_mask_t access_mask(mem_funct3_e funct3, logic [1:0] addr_lo);
        case (funct3[1:0])
            2'b00:   return byte_mask_t'(4'b0001 << addr_lo);
            2'b01:   return byte_mask_t'(4'b0011 << addr_lo);
            default: return 4'b1111;
        endcase
    endfunction

    // move the store data into the byte lanes it is written to
    function automatic word_t store_lanes(mem_funct3_e funct3, logic [1:0] addr_lo,
                                          word_t value);
        word_t lanes;
        lanes = '0;
        case (funct3[1:0])
            2'b00:   lanes[8*addr_lo +: 8] = value[7:0];
            2'b01:   lanes[16*addr_lo[1] +: 16] = value[15:0];
            default: lanes = value;
        endcase
        return lanes;
    endfunction

endpackage

//--- rtl/lsu_cfg_pkg.sv
package lsu_cfg_pkg;

    // pointers wrap by overflow, so the depth stays a power of two
    localparam int queue_depth  = 8;
    localparam int rob_id_width = 4;
    localparam int qptr_width   = $clog2(queue_depth);

    typedef logic [rob_id_width-1:0] rob_id_t;
    typedef logic [qptr_width-1:0]   qptr_t;

    // one extra bit so a full queue can be told from an empty one
    typedef logic [qptr_width:0]     qcount_t;

endpackage

//--- rtl/load_queue.sv
`timescale 1ns/1ns

module load_queue (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic                    disp_valid,
    input  logic                    disp_is_store,
    input  rv_mem_pkg::mem_funct3_e disp_funct3,
    input  lsu_cfg_pkg::rob_id_t    disp_rob_id,
    input  rv_mem_pkg::word_t       disp_imm,
    input  lsu_cfg_pkg::rob_id_t    disp_rs1_id,
    input  logic                    disp_rs1_ready,
    input  rv_mem_pkg::word_t       disp_rs1_value,
    input  logic                    cdb_valid,
    input  lsu_cfg_pkg::rob_id_t    cdb_rob_id,
    input  rv_mem_pkg::word_t       cdb_data,
    input  logic                    grant,
    output logic                    full,
    output logic                    sta_valid,
    output lsu_cfg_pkg::rob_id_t    sta_rob_id,
    output rv_mem_pkg::word_t       sta_addr,
    output rv_mem_pkg::byte_mask_t  sta_rmask,
    output rv_mem_pkg::mem_funct3_e sta_funct3
);
    import rv_mem_pkg::*;
    import lsu_cfg_pkg::*;

    mem_funct3_e funct3_q  [queue_depth];
    rob_id_t     rob_id_q  [queue_depth];
    word_t       imm_q     [queue_depth];
    rob_id_t     rs1_id_q  [queue_depth];
    logic        rs1_rdy_q [queue_depth];
    word_t       rs1_val_q [queue_depth];

    qptr_t   head;
    qptr_t   tail;
    qcount_t count;

    logic [queue_depth-1:0] in_use;
    logic  push;
    logic  pop;
    logic  head_ready;
    logic  rs1_hit;
    word_t head_addr;

    assign full       = (count == qcount_t'(queue_depth));
    assign push       = disp_valid && !disp_is_store && !full;
    assign head_ready = (count != '0) && rs1_rdy_q[head];
    // station takes the head when empty or when it is handed to memory this cycle
    assign pop        = head_ready && (!sta_valid || grant);
    // producer finishing in the dispatch cycle itself
    assign rs1_hit    = cdb_valid && (cdb_rob_id == disp_rs1_id);
    assign head_addr  = rs1_val_q[head] + imm_q[head];

    // occupied slots lie between head and head + count
    always_comb begin
        for (int i = 0; i < queue_depth; i++) begin
            in_use[i] = ({1'b0, qptr_t'(i) - head} < count);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            sta_valid <= 1'b0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (pop) begin
                sta_valid <= 1'b1;
            end else if (grant) begin
                sta_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        // wakeup from the result bus
        for (int i = 0; i < queue_depth; i++) begin
            if (in_use[i] && !rs1_rdy_q[i] && cdb_valid && (cdb_rob_id == rs1_id_q[i])) begin
                rs1_rdy_q[i] <= 1'b1;
                rs1_val_q[i] <= cdb_data;
            end
        end

        if (push) begin
            funct3_q[tail]  <= disp_funct3;
            rob_id_q[tail]  <= disp_rob_id;
            imm_q[tail]     <= disp_imm;
            rs1_id_q[tail]  <= disp_rs1_id;
            rs1_rdy_q[tail] <= disp_rs1_ready || rs1_hit;
            rs1_val_q[tail] <= disp_rs1_ready ? disp_rs1_value : cdb_data;
        end

        if (pop) begin
            sta_rob_id <= rob_id_q[head];
            sta_addr   <= head_addr;
            sta_rmask  <= access_mask(funct3_q[head], head_addr[1:0]);
            sta_funct3 <= funct3_q[head];
        end
    end

endmodule

//--- rtl/store_queue.sv
`timescale 1ns/1ns

module store_queue (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic                    disp_valid,
    input  logic                    disp_is_store,
    input  rv_mem_pkg::mem_funct3_e disp_funct3,
    input  lsu_cfg_pkg::rob_id_t    disp_rob_id,
    input  rv_mem_pkg::word_t       disp_imm,
    input  lsu_cfg_pkg::rob_id_t    disp_rs1_id,
    input  logic                    disp_rs1_ready,
    input  rv_mem_pkg::word_t       disp_rs1_value,
    input  lsu_cfg_pkg::rob_id_t    disp_rs2_id,
    input  logic                    disp_rs2_ready,
    input  rv_mem_pkg::word_t       disp_rs2_value,
    input  logic                    cdb_valid,
    input  lsu_cfg_pkg::rob_id_t    cdb_rob_id,
    input  rv_mem_pkg::word_t       cdb_data,
    input  logic                    grant,
    output logic                    full,
    output logic                    sta_valid,
    output lsu_cfg_pkg::rob_id_t    sta_rob_id,
    output rv_mem_pkg::word_t       sta_addr,
    output rv_mem_pkg::byte_mask_t  sta_wmask,
    output rv_mem_pkg::word_t       sta_wdata
);
    import rv_mem_pkg::*;
    import lsu_cfg_pkg::*;

    mem_funct3_e funct3_q  [queue_depth];
    rob_id_t     rob_id_q  [queue_depth];
    word_t       imm_q     [queue_depth];
    rob_id_t     rs1_id_q  [queue_depth];
    logic        rs1_rdy_q [queue_depth];
    word_t       rs1_val_q [queue_depth];
    rob_id_t     rs2_id_q  [queue_depth];
    logic        rs2_rdy_q [queue_depth];
    word_t       rs2_val_q [queue_depth];

    qptr_t   head;
    qptr_t   tail;
    qcount_t count;

    logic [queue_depth-1:0] in_use;
    logic  push;
    logic  pop;
    logic  head_ready;
    logic  rs1_hit;
    logic  rs2_hit;
    word_t head_addr;

    assign full       = (count == qcount_t'(queue_depth));
    assign push       = disp_valid && disp_is_store && !full;
    assign head_ready = (count != '0) && rs1_rdy_q[head] && rs2_rdy_q[head];
    assign pop        = head_ready && (!sta_valid || grant);
    assign rs1_hit    = cdb_valid && (cdb_rob_id == disp_rs1_id);
    assign rs2_hit    = cdb_valid && (cdb_rob_id == disp_rs2_id);
    assign head_addr  = rs1_val_q[head] + imm_q[head];

    always_comb begin
        for (int i = 0; i < queue_depth; i++) begin
            in_use[i] = ({1'b0, qptr_t'(i) - head} < count);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            sta_valid <= 1'b0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (pop) begin
                sta_valid <= 1'b1;
            end else if (grant) begin
                sta_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        // base and data operands wake up independently
        for (int i = 0; i < queue_depth; i++) begin
            if (in_use[i] && !rs1_rdy_q[i] && cdb_valid && (cdb_rob_id == rs1_id_q[i])) begin
                rs1_rdy_q[i] <= 1'b1;
                rs1_val_q[i] <= cdb_data;
            end
            if (in_use[i] && !rs2_rdy_q[i] && cdb_valid && (cdb_rob_id == rs2_id_q[i])) begin
                rs2_rdy_q[i] <= 1'b1;
                rs2_val_q[i] <= cdb_data;
            end
        end

        if (push) begin
            funct3_q[tail]  <= disp_funct3;
            rob_id_q[tail]  <= disp_rob_id;
            imm_q[tail]     <= disp_imm;
            rs1_id_q[tail]  <= disp_rs1_id;
            rs1_rdy_q[tail] <= disp_rs1_ready || rs1_hit;
            rs1_val_q[tail] <= disp_rs1_ready ? disp_rs1_value : cdb_data;
            rs2_id_q[tail]  <= disp_rs2_id;
            rs2_rdy_q[tail] <= disp_rs2_ready || rs2_hit;
            rs2_val_q[tail] <= disp_rs2_ready ? disp_rs2_value : cdb_data;
        end

        if (pop) begin
            sta_rob_id <= rob_id_q[head];
            sta_addr   <= head_addr;
            sta_wmask  <= access_mask(funct3_q[head], head_addr[1:0]);
            sta_wdata  <= store_lanes(funct3_q[head], head_addr[1:0], rs2_val_q[head]);
        end
    end

endmodule

//--- rtl/mem_issue_arbiter.sv
`timescale 1ns/1ns

module mem_issue_arbiter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  lsu_cfg_pkg::rob_id_t    commit_head,
    input  logic                    ld_sta_valid,
    input  lsu_cfg_pkg::rob_id_t    ld_sta_rob_id,
    input  rv_mem_pkg::word_t       ld_sta_addr,
    input  rv_mem_pkg::byte_mask_t  ld_sta_rmask,
    input  rv_mem_pkg::mem_funct3_e ld_sta_funct3,
    input  logic                    st_sta_valid,
    input  lsu_cfg_pkg::rob_id_t    st_sta_rob_id,
    input  rv_mem_pkg::word_t       st_sta_addr,
    input  rv_mem_pkg::byte_mask_t  st_sta_wmask,
    input  rv_mem_pkg::word_t       st_sta_wdata,
    output logic                    ld_grant,
    output logic                    st_grant,
    output logic                    mem_valid,
    output logic                    mem_write,
    output rv_mem_pkg::word_t       mem_addr,
    output rv_mem_pkg::byte_mask_t  mem_rmask,
    output rv_mem_pkg::byte_mask_t  mem_wmask,
    output rv_mem_pkg::word_t       mem_wdata,
    output rv_mem_pkg::mem_funct3_e mem_funct3,
    output lsu_cfg_pkg::rob_id_t    mem_rob_id,
    input  logic                    mem_ready
);
    import rv_mem_pkg::*;

    logic active;
    logic ld_elig;
    logic st_elig;
    logic pick_store;
    logic xfer;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active <= 1'b0;
        end else begin
            active <= 1'b1;
        end
    end

    // only the instruction at the commit head may touch memory
    assign ld_elig    = ld_sta_valid && (ld_sta_rob_id == commit_head);
    assign st_elig    = st_sta_valid && (st_sta_rob_id == commit_head);
    assign pick_store = st_elig;

    assign mem_valid  = active && (st_elig || ld_elig);
    assign mem_write  = pick_store;
    assign mem_addr   = pick_store ? st_sta_addr : ld_sta_addr;
    assign mem_rmask  = pick_store ? byte_mask_t'('0) : ld_sta_rmask;
    assign mem_wmask  = pick_store ? st_sta_wmask : byte_mask_t'('0);
    assign mem_wdata  = pick_store ? st_sta_wdata : word_t'('0);
    // funct3 is only meaningful for loads
    assign mem_funct3 = pick_store ? sw : ld_sta_funct3;
    assign mem_rob_id = pick_store ? st_sta_rob_id : ld_sta_rob_id;

    assign xfer     = mem_valid && mem_ready;
    assign st_grant = xfer && pick_store;
    assign ld_grant = xfer && !pick_store;

endmodule

//--- rtl/load_store_unit.sv
`timescale 1ns/1ns

module load_store_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic                    disp_valid,
    input  logic                    disp_is_store,
    input  rv_mem_pkg::mem_funct3_e disp_funct3,
    input  lsu_cfg_pkg::rob_id_t    disp_rob_id,
    input  rv_mem_pkg::word_t       disp_imm,
    input  lsu_cfg_pkg::rob_id_t    disp_rs1_id,
    input  logic                    disp_rs1_ready,
    input  rv_mem_pkg::word_t       disp_rs1_value,
    input  lsu_cfg_pkg::rob_id_t    disp_rs2_id,
    input  logic                    disp_rs2_ready,
    input  rv_mem_pkg::word_t       disp_rs2_value,
    input  logic                    cdb_valid,
    input  lsu_cfg_pkg::rob_id_t    cdb_rob_id,
    input  rv_mem_pkg::word_t       cdb_data,
    input  lsu_cfg_pkg::rob_id_t    commit_head,
    output logic                    lq_full,
    output logic                    sq_full,
    output logic                    mem_valid,
    output logic                    mem_write,
    output rv_mem_pkg::word_t       mem_addr,
    output rv_mem_pkg::byte_mask_t  mem_rmask,
    output rv_mem_pkg::byte_mask_t  mem_wmask,
    output rv_mem_pkg::word_t       mem_wdata,
    output rv_mem_pkg::mem_funct3_e mem_funct3,
    output lsu_cfg_pkg::rob_id_t    mem_rob_id,
    input  logic                    mem_ready
);
    import rv_mem_pkg::*;
    import lsu_cfg_pkg::*;

    logic        ld_grant;
    logic        ld_sta_valid;
    rob_id_t     ld_sta_rob_id;
    word_t       ld_sta_addr;
    byte_mask_t  ld_sta_rmask;
    mem_funct3_e ld_sta_funct3;

    logic        st_grant;
    logic        st_sta_valid;
    rob_id_t     st_sta_rob_id;
    word_t       st_sta_addr;
    byte_mask_t  st_sta_wmask;
    word_t       st_sta_wdata;

    load_queue i_load_queue (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .disp_valid     (disp_valid),
        .disp_is_store  (disp_is_store),
        .disp_funct3    (disp_funct3),
        .disp_rob_id    (disp_rob_id),
        .disp_imm       (disp_imm),
        .disp_rs1_id    (disp_rs1_id),
        .disp_rs1_ready (disp_rs1_ready),
        .disp_rs1_value (disp_rs1_value),
        .cdb_valid      (cdb_valid),
        .cdb_rob_id     (cdb_rob_id),
        .cdb_data       (cdb_data),
        .grant          (ld_grant),
        .full           (lq_full),
        .sta_valid      (ld_sta_valid),
        .sta_rob_id     (ld_sta_rob_id),
        .sta_addr       (ld_sta_addr),
        .sta_rmask      (ld_sta_rmask),
        .sta_funct3     (ld_sta_funct3)
    );

    store_queue i_store_queue (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .disp_valid     (disp_valid),
        .disp_is_store  (disp_is_store),
        .disp_funct3    (disp_funct3),
        .disp_rob_id    (disp_rob_id),
        .disp_imm       (disp_imm),
        .disp_rs1_id    (disp_rs1_id),
        .disp_rs1_ready (disp_rs1_ready),
        .disp_rs1_value (disp_rs1_value),
        .disp_rs2_id    (disp_rs2_id),
        .disp_rs2_ready (disp_rs2_ready),
        .disp_rs2_value (disp_rs2_value),
        .cdb_valid      (cdb_valid),
        .cdb_rob_id     (cdb_rob_id),
        .cdb_data       (cdb_data),
        .grant          (st_grant),
        .full           (sq_full),
        .sta_valid      (st_sta_valid),
        .sta_rob_id     (st_sta_rob_id),
        .sta_addr       (st_sta_addr),
        .sta_wmask      (st_sta_wmask),
        .sta_wdata      (st_sta_wdata)
    );

    mem_issue_arbiter i_mem_issue_arbiter (
        .clk           (clk),
        .rst_n         (rst_n),
        .commit_head   (commit_head),
        .ld_sta_valid  (ld_sta_valid),
        .ld_sta_rob_id (ld_sta_rob_id),
        .ld_sta_addr   (ld_sta_addr),
        .ld_sta_rmask  (ld_sta_rmask),
        .ld_sta_funct3 (ld_sta_funct3),
        .st_sta_valid  (st_sta_valid),
        .st_sta_rob_id (st_sta_rob_id),
        .st_sta_addr   (st_sta_addr),
        .st_sta_wmask  (st_sta_wmask),
        .st_sta_wdata  (st_sta_wdata),
        .ld_grant      (ld_grant),
        .st_grant      (st_grant),
        .mem_valid     (mem_valid),
        .mem_write     (mem_write),
        .mem_addr      (mem_addr),
        .mem_rmask     (mem_rmask),
        .mem_wmask     (mem_wmask),
        .mem_wdata     (mem_wdata),
        .mem_funct3    (mem_funct3),
        .mem_rob_id    (mem_rob_id),
        .mem_ready     (mem_ready)
    );

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    localparam int half_period  = 4;
    localparam int reset_cycles = 8;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        // release on the falling edge, away from the sampling edge
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- test/tb_load_store_unit.sv
`timescale 1ns/1ns

module tb_load_store_unit;
    import rv_mem_pkg::*;
    import lsu_cfg_pkg::*;

    localparam int n_ops          = 200;
    localparam int flush_point    = 100;
    localparam int rob_entries    = 1 << rob_id_width;
    localparam int timeout_cycles = n_ops * 40;

    logic        clk;
    logic        rst_n;
    logic        flush;
    logic        disp_valid;
    logic        disp_is_store;
    mem_funct3_e disp_funct3;
    rob_id_t     disp_rob_id;
    word_t       disp_imm;
    rob_id_t     disp_rs1_id;
    logic        disp_rs1_ready;
    word_t       disp_rs1_value;
    rob_id_t     disp_rs2_id;
    logic        disp_rs2_ready;
    word_t       disp_rs2_value;
    logic        cdb_valid;
    rob_id_t     cdb_rob_id;
    word_t       cdb_data;
    rob_id_t     commit_head;
    logic        lq_full;
    logic        sq_full;
    logic        mem_valid;
    logic        mem_write;
    word_t       mem_addr;
    byte_mask_t  mem_rmask;
    byte_mask_t  mem_wmask;
    word_t       mem_wdata;
    mem_funct3_e mem_funct3;
    rob_id_t     mem_rob_id;
    logic        mem_ready;

    // the program with one slot per memory operation
    logic        op_store   [n_ops];
    mem_funct3_e op_f3      [n_ops];
    rob_id_t     op_rob     [n_ops];
    word_t       op_imm     [n_ops];
    rob_id_t     op_rs1_id  [n_ops];
    logic        op_rs1_rdy [n_ops];
    word_t       op_rs1_val [n_ops];
    rob_id_t     op_rs2_id  [n_ops];
    logic        op_rs2_rdy [n_ops];
    word_t       op_rs2_val [n_ops];

    // producer results still to be put on the broadcast bus
    logic  sched_valid [rob_entries];
    word_t sched_value [rob_entries];
    int    sched_due   [rob_entries];

    logic [31:0] lfsr_state;
    int          cycle;
    int          cycle_count = 0;
    int          disp_ptr;
    int          commit_ptr;
    int          ld_out;
    int          st_out;
    rob_id_t     head_id;
    logic        flushed;
    logic        stalled;
    logic        held_write;
    word_t       held_addr;
    byte_mask_t  held_rmask;
    byte_mask_t  held_wmask;
    word_t       held_wdata;
    mem_funct3_e held_f3;

    tb_clock_gen i_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    load_store_unit i_dut (.*);

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[31]};
        end
        return v;
    endfunction

    function automatic byte_mask_t expect_mask(logic [2:0] f3, logic [1:0] lo);
        byte_mask_t m;
        int         nbytes;
        nbytes = (f3[1:0] == 2'b00) ? 1 : ((f3[1:0] == 2'b01) ? 2 : 4);
        // bytes pushed past lane 3 fall off the word
        for (int b = 0; b < 4; b++) begin
            m[b] = (nbytes == 4) || ((b >= int'(lo)) && (b < int'(lo) + nbytes));
        end
        return m;
    endfunction

    function automatic word_t expect_wdata(logic [2:0] f3, logic [1:0] lo, word_t value);
        word_t d;
        int    lane;
        int    nbytes;
        if (f3[1:0] == 2'b00) begin
            lane   = int'(lo);
            nbytes = 1;
        end else if (f3[1:0] == 2'b01) begin
            lane   = 2 * int'(lo[1]);
            nbytes = 2;
        end else begin
            lane   = 0;
            nbytes = 4;
        end
        d = '0;
        for (int k = 0; k < nbytes; k++) begin
            d[8*(lane+k) +: 8] = value[8*k +: 8];
        end
        return d;
    endfunction

    // a pending operand joins a producer already waiting to broadcast or schedules one
    function automatic word_t bind_operand(rob_id_t pid, logic ready, word_t val);
        logic [31:0] r;
        if (ready) begin
            return val;
        end
        if (sched_valid[pid]) begin
            return sched_value[pid];
        end
        r = rand_bits(4);
        sched_valid[pid] = 1'b1;
        sched_value[pid] = val;
        sched_due[pid]   = cycle + int'(r);
        return val;
    endfunction

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Regression failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic make_program(input int first, input rob_id_t first_id);
        logic [31:0] r;
        for (int i = first; i < n_ops; i++) begin
            op_rob[i] = first_id + rob_id_t'(i - first);
            r = rand_bits(1);
            op_store[i] = r[0];
            r = rand_bits(3);
            if (op_store[i]) begin
                case (r % 3)
                    32'd0:   op_f3[i] = sb;
                    32'd1:   op_f3[i] = sh;
                    default: op_f3[i] = sw;
                endcase
            end else begin
                case (r % 5)
                    32'd0:   op_f3[i] = lb;
                    32'd1:   op_f3[i] = lh;
                    32'd2:   op_f3[i] = lw;
                    32'd3:   op_f3[i] = lbu;
                    default: op_f3[i] = lhu;
                endcase
            end
            r = rand_bits(12);
            op_imm[i] = {{20{r[11]}}, r[11:0]};
            op_rs1_val[i] = rand_bits(32);
            op_rs2_val[i] = rand_bits(32);
            r = rand_bits(1);
            op_rs1_rdy[i] = r[0];
            r = rand_bits(1);
            // loads have no data operand
            op_rs2_rdy[i] = r[0] || !op_store[i];
            r = rand_bits(4);
            op_rs1_id[i] = r[3:0];
            r = rand_bits(4);
            op_rs2_id[i] = r[3:0];
        end
    endtask

    task automatic dispatch_op(input int i);
        op_rs1_val[i]  = bind_operand(op_rs1_id[i], op_rs1_rdy[i], op_rs1_val[i]);
        op_rs2_val[i]  = bind_operand(op_rs2_id[i], op_rs2_rdy[i], op_rs2_val[i]);
        disp_valid     = 1'b1;
        disp_is_store  = op_store[i];
        disp_funct3    = op_f3[i];
        disp_rob_id    = op_rob[i];
        disp_imm       = op_imm[i];
        disp_rs1_id    = op_rs1_id[i];
        disp_rs1_ready = op_rs1_rdy[i];
        disp_rs2_id    = op_rs2_id[i];
        disp_rs2_ready = op_rs2_rdy[i];
        // a pending operand carries junk that must never be used
        disp_rs1_value = op_rs1_rdy[i] ? op_rs1_val[i] : ~op_rs1_val[i];
        disp_rs2_value = op_rs2_rdy[i] ? op_rs2_val[i] : ~op_rs2_val[i];
        if (op_store[i]) begin
            st_out++;
        end else begin
            ld_out++;
        end
    endtask

    task automatic send_broadcast();
        for (int p = 0; p < rob_entries; p++) begin
            if (!cdb_valid && sched_valid[p] && (sched_due[p] <= cycle)) begin
                cdb_valid      = 1'b1;
                cdb_rob_id     = rob_id_t'(p);
                cdb_data       = sched_value[p];
                sched_valid[p] = 1'b0;
            end
        end
    endtask

    task automatic observe_request(input int disp_before);
        word_t addr;
        int    c;
        if (stalled) begin
            check_equal(32'(mem_valid), 32'd1, "mem_valid while stalled");
            check_equal(32'(mem_write), 32'(held_write), "mem_write while stalled");
            check_equal(mem_addr, held_addr, "mem_addr while stalled");
            check_equal(32'(mem_rmask), 32'(held_rmask), "mem_rmask while stalled");
            check_equal(32'(mem_wmask), 32'(held_wmask), "mem_wmask while stalled");
            check_equal(mem_wdata, held_wdata, "mem_wdata while stalled");
            check_equal(32'(mem_funct3), 32'(held_f3), "mem_funct3 while stalled");
        end
        stalled = 1'b0;
        if (mem_valid) begin
            check_equal(32'(commit_ptr < disp_before), 32'd1, "head dispatched before request");
            check_equal(32'(mem_rob_id), 32'(head_id), "mem_rob_id");
            c    = commit_ptr;
            addr = op_rs1_val[c] + op_imm[c];
            check_equal(32'(mem_write), 32'(op_store[c]), "mem_write");
            check_equal(mem_addr, addr, "mem_addr");
            if (op_store[c]) begin
                check_equal(32'(mem_wmask), 32'(expect_mask(op_f3[c], addr[1:0])), "mem_wmask");
                check_equal(mem_wdata, expect_wdata(op_f3[c], addr[1:0], op_rs2_val[c]),
                            "mem_wdata");
            end else begin
                check_equal(32'(mem_rmask), 32'(expect_mask(op_f3[c], addr[1:0])), "mem_rmask");
                check_equal(32'(mem_funct3), 32'(op_f3[c]), "mem_funct3");
            end
            if (mem_ready) begin
                if (op_store[c]) begin
                    st_out--;
                end else begin
                    ld_out--;
                end
                commit_ptr++;
                head_id = head_id + 1'b1;
            end else begin
                stalled    = 1'b1;
                held_write = mem_write;
                held_addr  = mem_addr;
                held_rmask = mem_rmask;
                held_wmask = mem_wmask;
                held_wdata = mem_wdata;
                held_f3    = mem_funct3;
            end
        end
    endtask

    task automatic run_cycle();
        int          disp_before;
        logic [31:0] r;
        @(negedge clk);
        cycle++;
        disp_valid  = 1'b0;
        cdb_valid   = 1'b0;
        flush       = 1'b0;
        commit_head = head_id;
        disp_before = disp_ptr;
        if (lq_full) begin
            check_equal(32'(ld_out >= queue_depth), 32'd1, "loads outstanding at lq_full");
        end
        if (sq_full) begin
            check_equal(32'(st_out >= queue_depth), 32'd1, "stores outstanding at sq_full");
        end
        r = rand_bits(2);
        if ((disp_ptr < n_ops) && (disp_ptr - commit_ptr < rob_entries) && (r != 32'd0)) begin
            if (op_store[disp_ptr] ? !sq_full : !lq_full) begin
                dispatch_op(disp_ptr);
                disp_ptr++;
            end
        end
        send_broadcast();
        r = rand_bits(2);
        mem_ready = (r != 32'd0);
        #1;
        observe_request(disp_before);
    endtask

    // a mispredict drops everything in flight and restarts after the last dispatched id
    task automatic flush_cycle();
        rob_id_t next_id;
        @(negedge clk);
        cycle++;
        disp_valid  = 1'b0;
        cdb_valid   = 1'b0;
        mem_ready   = 1'b0;
        flush       = 1'b1;
        commit_head = head_id;
        next_id = (disp_ptr > commit_ptr) ? op_rob[disp_ptr-1] + 1'b1 : head_id;
        for (int p = 0; p < rob_entries; p++) begin
            sched_valid[p] = 1'b0;
        end
        make_program(commit_ptr, next_id);
        disp_ptr = commit_ptr;
        head_id  = next_id;
        ld_out   = 0;
        st_out   = 0;
        stalled  = 1'b0;
        flushed  = 1'b1;
        @(posedge clk);
        #1;
        check_equal(32'(mem_valid), 32'd0, "mem_valid after flush");
        check_equal(32'(lq_full), 32'd0, "lq_full after flush");
        check_equal(32'(sq_full), 32'd0, "sq_full after flush");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: operations still not committed after %0d cycles", timeout_cycles);
            $display("Regression failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        flush          = 1'b0;
        disp_valid     = 1'b0;
        disp_is_store  = 1'b0;
        disp_funct3    = lb;
        disp_rob_id    = '0;
        disp_imm       = '0;
        disp_rs1_id    = '0;
        disp_rs1_ready = 1'b0;
        disp_rs1_value = '0;
        disp_rs2_id    = '0;
        disp_rs2_ready = 1'b0;
        disp_rs2_value = '0;
        cdb_valid      = 1'b0;
        cdb_rob_id     = '0;
        cdb_data       = '0;
        commit_head    = '0;
        mem_ready      = 1'b0;
        lfsr_state     = 32'hf9706f00;
        cycle          = 0;
        disp_ptr       = 0;
        commit_ptr     = 0;
        ld_out         = 0;
        st_out         = 0;
        head_id        = '0;
        flushed        = 1'b0;
        stalled        = 1'b0;
        for (int p = 0; p < rob_entries; p++) begin
            sched_valid[p] = 1'b0;
        end
        make_program(0, '0);

        wait (rst_n === 1'b1);
        @(posedge clk);
        #1;
        check_equal(32'(mem_valid), 32'd0, "mem_valid after reset");
        check_equal(32'(lq_full), 32'd0, "lq_full after reset");
        check_equal(32'(sq_full), 32'd0, "sq_full after reset");

        while (commit_ptr < n_ops) begin
            if (!flushed && (commit_ptr == flush_point)) begin
                flush_cycle();
            end else begin
                run_cycle();
            end
        end

        // every operation has gone out once, so memory must see nothing more
        repeat (4) begin
            @(negedge clk);
            disp_valid  = 1'b0;
            cdb_valid   = 1'b0;
            commit_head = head_id;
            mem_ready   = 1'b1;
            #1;
            check_equal(32'(mem_valid), 32'd0, "mem_valid after the last operation");
        end

        $display("Regression passed");
        $finish;
    end

endmodule

//--- sources.f
rtl/rv_mem_pkg.sv
rtl/lsu_cfg_pkg.sv
rtl/load_queue.sv
rtl/store_queue.sv
rtl/mem_issue_arbiter.sv
rtl/load_store_unit.sv
test/tb_clock_gen.sv
test/tb_load_store_unit.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_load_store_unit
FILELIST  = sources.f
BUILD_DIR = obj_dir
PASS_MSG  = Regression passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
